// File: bench/clock_reset_gen.sv
// Clock and reset source

`timescale 1ns/1ps

module clock_reset_gen (
  output logic aclk,
  output logic aresetn
);

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;  // 8 ns period
  end

  // Held low over three rising edges
  initial begin
    aresetn = 1'b0;
    repeat (3) @(posedge aclk);
    #1 aresetn = 1'b1;
  end

endmodule

// File: bench/r_channel_checker.sv
// R and AR channel protocol checker

`timescale 1ns/1ps

module r_channel_checker
  import axi_map_pkg::*;
  import axi_bus_pkg::*;
(
  input logic                  aclk,
  input logic                  aresetn,
  input logic                  arvalid,
  input logic [num_slaves-1:0] arvalid_s,
  input logic                  rvalid,
  input logic                  rready,
  input logic [id_w-1:0]       rid,
  input logic [data_w-1:0]     rdata,
  input logic [resp_w-1:0]     rresp,
  input logic                  rlast,
  input logic [num_slaves-1:0] rready_s
);

  // Stalled beat stays put until it transfers
  bp_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    (rvalid && !rready) |=> (rvalid && $stable(rid) && $stable(rdata)
                             && $stable(rresp) && $stable(rlast)))
    else $error("stalled R beat changed before it transferred");

  ready_onehot: assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0(rready_s))
    else $error("more than one slave sees rready at once");

  // No ready leaks to a slave while the master stalls
  ready_gated: assert property (@(posedge aclk) disable iff (!aresetn)
    !rready |-> (rready_s == '0))
    else $error("a slave sees rready while the master holds it low");

  ar_idle: assert property (@(posedge aclk) disable iff (!aresetn)
    !arvalid |-> (arvalid_s == '0))
    else $error("a slave sees arvalid while the master is idle");

  reset_quiet: assert property (@(posedge aclk)
    !aresetn |-> (!rvalid && (rready_s == '0)))
    else $error("R channel is active during reset");

endmodule

bind axi_read_xbar r_channel_checker u_r_checker (.*);

// File: bench/tb_axi_read_xbar.sv
// Read crossbar testbench

`timescale 1ns/1ps

module tb_axi_read_xbar
  import axi_map_pkg::*;
  import axi_bus_pkg::*;
();

  localparam int num_req     = 300;
  localparam int stim_limit  = 20000;
  localparam int drain_limit = 2000;
  localparam int reset_limit = 20;
  localparam int num_tests   = 6;

  logic                              aclk;
  logic                              aresetn;
  logic [addr_w-1:0]                 araddr;
  logic                              arvalid;
  logic                              arready;
  logic [num_slaves-1:0]             arvalid_s;
  logic [num_slaves-1:0]             arready_s;
  logic                              rvalid;
  logic [data_w-1:0]                 rdata;
  logic [id_w-1:0]                   rid;
  logic [resp_w-1:0]                 rresp;
  logic                              rlast;
  logic                              rready;
  logic [num_slaves-1:0]             rvalid_s;
  logic [num_slaves-1:0][data_w-1:0] rdata_s;
  logic [num_slaves-1:0][id_w-1:0]   rid_s;
  logic [num_slaves-1:0][resp_w-1:0] rresp_s;
  logic [num_slaves-1:0]             rlast_s;
  logic [num_slaves-1:0]             rready_s;

  integer seed;

  // Slave models
  logic [addr_w-1:0]      slv_q [num_slaves][$];  // Accepted requests, oldest first
  logic [7:0]             slv_beat [num_slaves];
  logic [num_slaves-1:0]  slv_fire;

  logic [data_w+resp_w:0] exp_q [num_slaves][$];  // {rlast, rresp, rdata}

  logic                   ar_fire;
  int                     req_sent;
  logic                   burst_open;
  logic [1:0]             burst_id;
  logic                   prio_pend;   // Burst start seen, first beat not yet taken
  logic [1:0]             prio_id;
  logic                   bp_prev;
  logic [id_w-1:0]        bp_rid;
  logic [data_w-1:0]      bp_rdata;
  logic                   timed_out;

  int    chk_cnt [num_tests];
  int    err_cnt [num_tests];
  string test_name [num_tests] = '{"reset", "routing", "data", "interleave",
                                   "priority", "backpressure"};

  clock_reset_gen u_clk_rst (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  axi_read_xbar UUT (.*);

  // Slave index from the address map
  function automatic logic [1:0] region_of(input logic [addr_w-1:0] a);
    if (a <= 40'h00_00ff_ffff) begin
      return 2'd0;
    end else if (a <= 40'h00_0fff_ffff) begin
      return 2'd1;
    end else if (a <= 40'h00_1fff_ffff) begin
      return 2'd2;
    end else begin
      return 2'd3;
    end
  endfunction

  function automatic logic [data_w-1:0] beat_data(input logic [7:0] idx,
                                                  input logic [addr_w-1:0] a,
                                                  input logic [7:0] beat);
    return data_w'({idx, a, beat});
  endfunction

  function automatic logic [1:0] lowest_valid(input logic [num_slaves-1:0] v);
    if (v[0]) begin
      return 2'd0;
    end else if (v[1]) begin
      return 2'd1;
    end else if (v[2]) begin
      return 2'd2;
    end else begin
      return 2'd3;
    end
  endfunction

  function automatic logic exp_busy();
    logic busy;
    busy = 1'b0;
    for (int i = 0; i < num_slaves; i++) begin
      if (exp_q[i].size() != 0) busy = 1'b1;
    end
    return busy;
  endfunction

  // Region picked evenly, sometimes right on an edge
  task automatic new_address();
    logic [31:0] r0;
    logic [31:0] r1;
    r0 = $random(seed);
    r1 = $random(seed);
    case (r0[31:30])
      2'd0: araddr = {16'h0000, r1[23:0]};
      2'd1: araddr = {8'h00, 32'h0100_0000 + (r1 % 32'h0f00_0000)};
      2'd2: araddr = {12'h001, r1[27:0]};
      default: begin
        araddr = {r0[7:0], r1};
        if (araddr < 40'h00_2000_0000) araddr[29] = 1'b1;
      end
    endcase
    if (r0[29:27] == 3'd0) begin
      case (r0[31:30])
        2'd0: araddr = sram_end;
        2'd1: araddr = err_lo_start;
        2'd2: araddr = apb_end;
        default: araddr = err_hi_start;
      endcase
    end
  endtask

  task automatic drive_cycle();
    logic [31:0]       rnd;
    logic [addr_w-1:0] a;
    if (!arvalid || ar_fire) begin  // Request held until accepted
      rnd = $random(seed);
      if (req_sent < num_req && rnd[1:0] != 2'd0) begin
        new_address();
        arvalid = 1'b1;
        req_sent++;
      end else begin
        arvalid = 1'b0;
      end
    end
    rnd = $random(seed);
    arready_s = rnd[num_slaves-1:0];
    rnd = $random(seed);
    rready = (rnd % 32'd10) < 32'd7;  // About 70% high
    for (int i = 0; i < num_slaves; i++) begin
      if (!rvalid_s[i] || slv_fire[i]) begin
        rnd = $random(seed);
        if (slv_q[i].size() != 0 && rnd[0]) begin
          a = slv_q[i][0];
          rvalid_s[i] = 1'b1;
          rdata_s[i]  = beat_data(8'(i), a, slv_beat[i]);
          rid_s[i]    = id_w'(i);
          rresp_s[i]  = (i == 1 || i == 3) ? resp_slverr : resp_okay;
          rlast_s[i]  = (slv_beat[i] == {6'd0, a[1:0]});
        end else begin
          rvalid_s[i] = 1'b0;
          rdata_s[i]  = '0;
          rid_s[i]    = '0;
          rresp_s[i]  = '0;
          rlast_s[i]  = 1'b0;
        end
      end
    end
  endtask

  task automatic sample_cycle();
    logic [1:0]             exp_s;
    logic [num_slaves-1:0]  exp_sel;
    logic [1:0]             src;
    logic [data_w+resp_w:0] head;
    logic                   r_fire;
    logic [addr_w-1:0]      a;
    r_fire   = rvalid && rready;
    ar_fire  = arvalid && arready;
    slv_fire = rvalid_s & rready_s;
    exp_s    = region_of(araddr);
    exp_sel  = '0;
    exp_sel[exp_s] = 1'b1;

    chk_cnt[1]++;
    if (arvalid) begin
      assert (arvalid_s == exp_sel) else begin
        $display("ERROR routing: arvalid_s for %h expected %b actual %b",
                 araddr, exp_sel, arvalid_s);
        err_cnt[1]++;
      end
      assert (arready == arready_s[exp_s]) else begin
        $display("ERROR routing: arready expected %b actual %b", arready_s[exp_s], arready);
        err_cnt[1]++;
      end
    end else begin
      assert (arvalid_s == '0) else begin
        $display("ERROR routing: idle arvalid_s expected 0000 actual %b", arvalid_s);
        err_cnt[1]++;
      end
    end
    if (ar_fire) begin
      for (int b = 0; b <= int'(araddr[1:0]); b++) begin
        exp_q[exp_s].push_back({b == int'(araddr[1:0]),
                                (exp_s == 2'd1 || exp_s == 2'd3) ? resp_slverr : resp_okay,
                                beat_data({6'd0, exp_s}, araddr, 8'(b))});
      end
    end

    if (bp_prev) begin
      chk_cnt[5]++;
      assert (rvalid && rid == bp_rid && rdata == bp_rdata) else begin
        $display("ERROR backpressure: held beat expected rid %h rdata %h actual rid %h rdata %h",
                 bp_rid, bp_rdata, rid, rdata);
        err_cnt[5]++;
      end
    end
    bp_prev = rvalid && !rready;
    if (bp_prev) begin
      chk_cnt[5]++;
      assert (rready_s == '0) else begin
        $display("ERROR backpressure: rready_s expected 0000 actual %b", rready_s);
        err_cnt[5]++;
      end
      bp_rid   = rid;
      bp_rdata = rdata;
    end

    // Burst start picks the lowest valid slave
    if (!burst_open && !prio_pend && rvalid_s != '0) begin
      prio_pend = 1'b1;
      prio_id   = lowest_valid(rvalid_s);
    end

    if (r_fire) begin
      src = rid[1:0];
      chk_cnt[2]++;
      assert (rid < 8'd4 && exp_q[src].size() != 0) else begin
        $display("data: beat with rid %h arrived with no request outstanding", rid);
        err_cnt[2]++;
      end
      if (rid < 8'd4 && exp_q[src].size() != 0) begin
        head = exp_q[src].pop_front();
        assert (rdata == head[data_w-1:0]) else begin
          $display("ERROR data: rdata expected %h actual %h", head[data_w-1:0], rdata);
          err_cnt[2]++;
        end
        assert (rresp == head[data_w+resp_w-1:data_w]) else begin
          $display("ERROR data: rresp expected %h actual %h",
                   head[data_w+resp_w-1:data_w], rresp);
          err_cnt[2]++;
        end
        assert (rlast == head[data_w+resp_w]) else begin
          $display("ERROR data: rlast expected %b actual %b", head[data_w+resp_w], rlast);
          err_cnt[2]++;
        end
      end
      if (burst_open) begin
        chk_cnt[3]++;
        assert (rid == {6'd0, burst_id}) else begin
          $display("ERROR interleave: rid expected %h actual %h", {6'd0, burst_id}, rid);
          err_cnt[3]++;
        end
      end
      burst_open = !rlast;
      burst_id   = src;
      if (prio_pend) begin
        chk_cnt[4]++;
        assert (rid == {6'd0, prio_id}) else begin
          $display("ERROR priority: first beat rid expected %h actual %h", {6'd0, prio_id}, rid);
          err_cnt[4]++;
        end
        prio_pend = 1'b0;
      end
    end

    // Slave side bookkeeping
    for (int i = 0; i < num_slaves; i++) begin
      if (slv_fire[i]) begin
        a = slv_q[i][0];
        if (slv_beat[i] == {6'd0, a[1:0]}) begin
          a = slv_q[i].pop_front();
          slv_beat[i] = 8'd0;
        end else begin
          slv_beat[i] = slv_beat[i] + 8'd1;
        end
      end
      if (arvalid_s[i] && arready_s[i]) slv_q[i].push_back(araddr);
    end
  endtask

  task automatic check_reset_state();
    chk_cnt[0]++;
    assert (rvalid == 1'b0 && rready_s == '0) else begin
      $display("ERROR reset: rvalid,rready_s expected 0,0000 actual %b,%b", rvalid, rready_s);
      err_cnt[0]++;
    end
  endtask

  task automatic run_cycle();
    @(posedge aclk);
    #1;
    drive_cycle();
    @(negedge aclk);
    sample_cycle();
  endtask

  task automatic print_test(input int t);
    $display("test %s: %0d checks, %0d errors", test_name[t], chk_cnt[t], err_cnt[t]);
  endtask

  initial begin
    int waited;
    int tot_chk;
    int tot_err;
    seed       = 59;
    araddr     = '0;
    arvalid    = 1'b0;
    arready_s  = '0;
    rready     = 1'b1;  // A stray grant would leak onto rready_s
    rvalid_s   = '0;
    rdata_s    = '0;
    rid_s      = '0;
    rresp_s    = '0;
    rlast_s    = '0;
    req_sent   = 0;
    ar_fire    = 1'b0;
    slv_fire   = '0;
    burst_open = 1'b0;
    burst_id   = 2'd0;
    prio_pend  = 1'b0;
    prio_id    = 2'd0;
    bp_prev    = 1'b0;
    bp_rid     = '0;
    bp_rdata   = '0;
    timed_out  = 1'b0;
    for (int t = 0; t < num_tests; t++) begin
      chk_cnt[t] = 0;
      err_cnt[t] = 0;
    end
    for (int i = 0; i < num_slaves; i++) begin
      slv_beat[i] = 8'd0;
    end

    @(posedge aclk);
    waited = 0;
    do begin
      @(negedge aclk);
      check_reset_state();
      waited++;
    end while (aresetn !== 1'b1 && waited < reset_limit);
    if (aresetn !== 1'b1) begin
      $display("reset was never released");
      timed_out = 1'b1;
    end
    print_test(0);

    if (!timed_out) begin
      waited = 0;
      while ((req_sent < num_req || arvalid) && waited < stim_limit) begin
        run_cycle();
        waited++;
      end
      if (req_sent < num_req || arvalid) begin
        $display("timed out before all read requests were accepted");
        timed_out = 1'b1;
      end
    end

    // Let every queued burst drain
    if (!timed_out) begin
      waited = 0;
      while (exp_busy() && waited < drain_limit) begin
        run_cycle();
        waited++;
      end
      chk_cnt[2]++;
      assert (!exp_busy()) else begin
        $display("data: timed out with read beats still undelivered");
        err_cnt[2]++;
        timed_out = 1'b1;
      end
    end

    tot_chk = 0;
    tot_err = 0;
    for (int t = 0; t < num_tests; t++) begin
      if (t != 0) print_test(t);
      tot_chk += chk_cnt[t];
      tot_err += err_cnt[t];
    end
    $display("total: %0d checks, %0d errors", tot_chk, tot_err);
    if (timed_out || tot_err != 0) begin
      $display(">>> FAIL");
    end else begin
      $display(">>> PASS");
    end
    $finish;
  end

endmodule

// File: design/ar_region_decoder.sv
// AR channel region decoder

`timescale 1ns/1ps

module ar_region_decoder
  import axi_map_pkg::*;
  import axi_bus_pkg::*;
(
  input  logic [addr_w-1:0]     araddr,
  input  logic                  arvalid,
  output logic [num_slaves-1:0] arvalid_s,
  input  logic [num_slaves-1:0] arready_s,
  output logic                  arready
);

  logic [num_slaves-1:0] ar_sel;   // One-hot region select
  logic                  in_sram;
  logic                  in_err_lo;
  logic                  in_apb;
  logic                  in_err_hi;

  // Range compares, inclusive at both ends
  assign in_sram   = (araddr >= sram_start)   && (araddr <= sram_end);
  assign in_err_lo = (araddr >= err_lo_start) && (araddr <= err_lo_end);
  assign in_apb    = (araddr >= apb_start)    && (araddr <= apb_end);
  assign in_err_hi = (araddr >= err_hi_start) && (araddr <= err_hi_end);

  // Bit position follows region_t order
  always_comb begin
    ar_sel         = '0;
    ar_sel[sram]   = in_sram;
    ar_sel[err_lo] = in_err_lo;
    ar_sel[apb]    = in_apb;
    ar_sel[err_hi] = in_err_hi;
  end

  // Request goes to the selected slave only
  assign arvalid_s = ar_sel & {num_slaves{arvalid}};

  // Map is complete, so exactly one bit survives
  assign arready = |(ar_sel & arready_s);

endmodule

// File: design/axi_bus_pkg.sv
// AXI read channel field widths

package axi_bus_pkg;

  // Address and data
  localparam int addr_w = 40;
  localparam int data_w = 128;

  // Transaction ID
  localparam int id_w   = 8;

  // Response field
  localparam int resp_w = 2;

  localparam logic [resp_w-1:0] resp_okay   = 2'b00;
  localparam logic [resp_w-1:0] resp_slverr = 2'b10; // Used by both error holes

endpackage

// File: design/axi_map_pkg.sv
// Read crossbar address map

package axi_map_pkg;

  // One slave port per region
  localparam int num_slaves = 4;

  // Slave index follows region order
  typedef enum logic [1:0] {
    sram   = 2'd0,
    err_lo = 2'd1,
    apb    = 2'd2,
    err_hi = 2'd3
  } region_t;

  // On-chip SRAM
  localparam logic [39:0] sram_start   = 40'h00_0000_0000;
  localparam logic [39:0] sram_end     = 40'h00_00ff_ffff;

  // Hole below the APB window
  localparam logic [39:0] err_lo_start = 40'h00_0100_0000;
  localparam logic [39:0] err_lo_end   = 40'h00_0fff_ffff;

  // APB bridge
  localparam logic [39:0] apb_start    = 40'h00_1000_0000;
  localparam logic [39:0] apb_end      = 40'h00_1fff_ffff;

  // Everything above, up to the top of the 40-bit space
  localparam logic [39:0] err_hi_start = 40'h00_2000_0000;
  localparam logic [39:0] err_hi_end   = 40'hff_ffff_ffff;

endpackage

// File: design/axi_read_xbar.sv
// Read-only AXI crossbar top

`timescale 1ns/1ps

module axi_read_xbar
  import axi_map_pkg::*;
  import axi_bus_pkg::*;
(
  input  logic                              aclk,
  input  logic                              aresetn,

  // Master AR
  input  logic [addr_w-1:0]                 araddr,
  input  logic                              arvalid,
  output logic                              arready,

  // Slave AR
  output logic [num_slaves-1:0]             arvalid_s,
  input  logic [num_slaves-1:0]             arready_s,

  // Master R
  output logic                              rvalid,
  output logic [data_w-1:0]                 rdata,
  output logic [id_w-1:0]                   rid,
  output logic [resp_w-1:0]                 rresp,
  output logic                              rlast,
  input  logic                              rready,

  // Slave R
  input  logic [num_slaves-1:0]             rvalid_s,
  input  logic [num_slaves-1:0][data_w-1:0] rdata_s,
  input  logic [num_slaves-1:0][id_w-1:0]   rid_s,
  input  logic [num_slaves-1:0][resp_w-1:0] rresp_s,
  input  logic [num_slaves-1:0]             rlast_s,
  output logic [num_slaves-1:0]             rready_s
);

  logic [num_slaves-1:0] r_grant;  // Current R channel owner

  ar_region_decoder u_ar_dec (
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arvalid_s (arvalid_s),
    .arready_s (arready_s),
    .arready   (arready)
  );

  r_owner_fsm u_r_fsm (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .rvalid_s (rvalid_s),
    .rlast_s  (rlast_s),
    .rready   (rready),
    .grant    (r_grant)
  );

  r_return_mux u_r_mux (
    .grant    (r_grant),
    .rvalid_s (rvalid_s),
    .rdata_s  (rdata_s),
    .rid_s    (rid_s),
    .rresp_s  (rresp_s),
    .rlast_s  (rlast_s),
    .rvalid   (rvalid),
    .rdata    (rdata),
    .rid      (rid),
    .rresp    (rresp),
    .rlast    (rlast),
    .rready   (rready),
    .rready_s (rready_s)
  );

endmodule

// File: design/r_owner_fsm.sv
// R channel burst owner FSM

`timescale 1ns/1ps

module r_owner_fsm
  import axi_map_pkg::*;
(
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic [num_slaves-1:0] rvalid_s,
  input  logic [num_slaves-1:0] rlast_s,
  input  logic                  rready,
  output logic [num_slaves-1:0] grant
);

  typedef enum logic {
    st_idle,
    st_locked
  } state_t;

  state_t  state_q;
  state_t  state_d;
  region_t owner_q;    // Slave holding the channel while locked
  region_t owner_d;
  region_t pick_idx;   // Fixed-priority winner in idle
  logic    pick_vld;
  logic    pick_done;  // Winner's beat is its last and goes through now
  logic    owner_done;

  // Lowest index with valid data wins
  always_comb begin
    pick_idx = sram;
    pick_vld = 1'b0;
    for (int i = num_slaves - 1; i >= 0; i--) begin
      if (rvalid_s[i]) begin
        pick_idx = region_t'(i);
        pick_vld = 1'b1;
      end
    end
  end

  assign pick_done  = rready & rlast_s[pick_idx];
  assign owner_done = rvalid_s[owner_q] & rready & rlast_s[owner_q];

  always_comb begin
    grant = '0;
    if (state_q == st_locked) begin
      grant[owner_q] = 1'b1;       // Other slaves wait for rlast
    end else if (pick_vld) begin
      grant[pick_idx] = 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    owner_d = owner_q;
    case (state_q)
      st_idle: begin
        // Single-beat burst accepted now needs no lock
        if (pick_vld && !pick_done) begin
          state_d = st_locked;
          owner_d = pick_idx;
        end
      end
      st_locked: begin
        if (owner_done) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state_q <= st_idle;
      owner_q <= sram;
    end else begin
      state_q <= state_d;
      owner_q <= owner_d;
    end
  end

endmodule

// File: design/r_return_mux.sv
// R channel return multiplexer

`timescale 1ns/1ps

module r_return_mux
  import axi_map_pkg::*;
  import axi_bus_pkg::*;
(
  input  logic [num_slaves-1:0]             grant,
  input  logic [num_slaves-1:0]             rvalid_s,
  input  logic [num_slaves-1:0][data_w-1:0] rdata_s,
  input  logic [num_slaves-1:0][id_w-1:0]   rid_s,
  input  logic [num_slaves-1:0][resp_w-1:0] rresp_s,
  input  logic [num_slaves-1:0]             rlast_s,
  output logic                              rvalid,
  output logic [data_w-1:0]                 rdata,
  output logic [id_w-1:0]                   rid,
  output logic [resp_w-1:0]                 rresp,
  output logic                              rlast,
  input  logic                              rready,
  output logic [num_slaves-1:0]             rready_s
);

  // Grant is one-hot or zero, so at most one slave is picked
  always_comb begin
    rvalid = 1'b0;
    rdata  = '0;
    rid    = '0;
    rresp  = resp_okay;
    rlast  = 1'b0;
    for (int i = 0; i < num_slaves; i++) begin
      if (grant[i]) begin
        rvalid = rvalid_s[i];
        rdata  = rdata_s[i];
        rid    = rid_s[i];
        rresp  = rresp_s[i];
        rlast  = rlast_s[i];
      end
    end
  end

  // Master's ready reaches the owner alone
  assign rready_s = grant & {num_slaves{rready}};

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the read crossbar testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 \
  --top-module tb_axi_read_xbar -f src.f -o tb_axi_read_xbar \
  && ./obj_dir/tb_axi_read_xbar | tee /dev/stderr | grep -x '>>> PASS' > /dev/null \
  && echo "simulation result: passed" \
  || { echo "simulation result: failed"; exit 1; }

// File: src.f
design/axi_map_pkg.sv
design/axi_bus_pkg.sv
design/ar_region_decoder.sv
design/r_owner_fsm.sv
design/r_return_mux.sv
design/axi_read_xbar.sv
bench/clock_reset_gen.sv
bench/r_channel_checker.sv
bench/tb_axi_read_xbar.sv
